// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_loopback_msg
FILELIST   := filelist.f
COMMON     := --timing -Wno-fatal
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dest_tag_table.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module dest_tag_table
    import loopback_stream_pkg::*;
(
    input  logic                             clk,
    input  logic                             wr_en,
    input  tag_index_t                       wr_index,
    input  msg_tag_t                         wr_tag,
    input  tag_index_t [`LB_PORT_COUNT-1:0]  rd_index,
    output msg_tag_t   [`LB_PORT_COUNT-1:0]  rd_tag
);

    localparam int ENTRIES = 2 ** $bits(tag_index_t);

    // one destination tag per core/slot pair.
    msg_tag_t tag_mem [ENTRIES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    // lookup per stream port, no latency.
    always_comb begin
        for (int p = 0; p < `LB_PORT_COUNT; p++) begin
            rd_tag[p] = tag_mem[rd_index[p]];
        end
    end

endmodule

// File: filelist.f
+incdir+.
loopback_stream_pkg.sv
loopback_bus_pkg.sv
dest_tag_table.sv
loopback_stream_fifo.sv
frame_counter.sv
msg_bus_fsm.sv
loopback_msg_top.sv
tb_loopback_msg.sv

// File: frame_counter.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module frame_counter
    import loopback_bus_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic         [`LB_PORT_COUNT-1:0]   beat_valid,
    input  logic         [`LB_PORT_COUNT-1:0]   beat_ready,
    input  logic         [`LB_PORT_COUNT-1:0]   beat_last,
    output frame_count_t [`LB_PORT_COUNT-1:0]   count
);

    logic [`LB_PORT_COUNT-1:0] frame_done;

    // last beat handshaked on the output stream.
    assign frame_done = beat_valid & beat_ready & beat_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            for (int p = 0; p < `LB_PORT_COUNT; p++) begin
                if (frame_done[p]) begin
                    count[p] <= count[p] + 1'b1;
                end
            end
        end
    end

endmodule

// File: loopback_bus_pkg.sv
`include "loopback_settings.svh"

package loopback_bus_pkg;

    // word address. bit 7 low selects a table entry, high a frame counter.
    typedef logic [7:0] wb_addr_t;

    typedef logic [15:0] wb_data_t;

    // completed output frames, wraps.
    typedef logic [`LB_COUNT_WIDTH-1:0] frame_count_t;

    typedef enum logic [1:0] {
        bus_idle  = 2'd0,
        bus_write = 2'd1,
        bus_read  = 2'd2,
        bus_ack   = 2'd3
    } bus_state_t;

endpackage

// File: loopback_msg_top.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module loopback_msg_top
    import loopback_stream_pkg::*;
    import loopback_bus_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,

    // frames from the cores, tuser is the source tag.
    input  stream_data_t [`LB_PORT_COUNT-1:0]   s_tdata,
    input  stream_keep_t [`LB_PORT_COUNT-1:0]   s_tkeep,
    input  logic         [`LB_PORT_COUNT-1:0]   s_tvalid,
    input  logic         [`LB_PORT_COUNT-1:0]   s_tlast,
    input  msg_tag_t     [`LB_PORT_COUNT-1:0]   s_tuser,
    input  port_num_t    [`LB_PORT_COUNT-1:0]   s_tdest,
    output logic         [`LB_PORT_COUNT-1:0]   s_tready,

    // frames back to the cores, tdest is the looked-up tag.
    output stream_data_t [`LB_PORT_COUNT-1:0]   m_tdata,
    output stream_keep_t [`LB_PORT_COUNT-1:0]   m_tkeep,
    output logic         [`LB_PORT_COUNT-1:0]   m_tvalid,
    output logic         [`LB_PORT_COUNT-1:0]   m_tlast,
    output msg_tag_t     [`LB_PORT_COUNT-1:0]   m_tdest,
    output port_num_t    [`LB_PORT_COUNT-1:0]   m_tuser,
    input  logic         [`LB_PORT_COUNT-1:0]   m_tready,

    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  wb_addr_t                            wb_adr,
    input  wb_data_t                            wb_dat_w,
    output wb_data_t                            wb_dat_r,
    output logic                                wb_ack
);

    tag_index_t   [`LB_PORT_COUNT-1:0] lookup_index;
    msg_tag_t     [`LB_PORT_COUNT-1:0] lookup_tag;
    frame_count_t [`LB_PORT_COUNT-1:0] frame_count;

    logic       tbl_wr_en;
    tag_index_t tbl_wr_index;
    msg_tag_t   tbl_wr_tag;

    // **********************************************************************
    // control path.
    // **********************************************************************

    msg_bus_fsm i_bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .frame_count  (frame_count),
        .tbl_wr_en    (tbl_wr_en),
        .tbl_wr_index (tbl_wr_index),
        .tbl_wr_tag   (tbl_wr_tag)
    );

    dest_tag_table i_table (
        .clk      (clk),
        .wr_en    (tbl_wr_en),
        .wr_index (tbl_wr_index),
        .wr_tag   (tbl_wr_tag),
        .rd_index (lookup_index),
        .rd_tag   (lookup_tag)
    );

    frame_counter i_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (m_tvalid),
        .beat_ready (m_tready),
        .beat_last  (m_tlast),
        .count      (frame_count)
    );

    // **********************************************************************
    // per-port data path.
    // **********************************************************************

    for (genvar p = 0; p < `LB_PORT_COUNT; p++) begin : g_port
        // core bits from the top of the tag, slot bits from the bottom.
        assign lookup_index[p] = {s_tuser[p][`LB_TAG_WIDTH-1 -: `LB_CORE_WIDTH],
                                  s_tuser[p][`LB_SLOT_WIDTH-1:0]};

        loopback_stream_fifo #(
            .DEPTH (`LB_FIFO_DEPTH)
        ) i_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_data   (s_tdata[p]),
            .in_keep   (s_tkeep[p]),
            .in_last   (s_tlast[p]),
            .in_port   (s_tdest[p]),
            .in_tag    (lookup_tag[p]),
            .in_valid  (s_tvalid[p]),
            .in_ready  (s_tready[p]),
            .out_data  (m_tdata[p]),
            .out_keep  (m_tkeep[p]),
            .out_last  (m_tlast[p]),
            .out_port  (m_tuser[p]),
            .out_tag   (m_tdest[p]),
            .out_valid (m_tvalid[p]),
            .out_ready (m_tready[p])
        );
    end

endmodule

// File: loopback_settings.svh
`ifndef LOOPBACK_SETTINGS_SVH
`define LOOPBACK_SETTINGS_SVH

// stream port geometry.
`define LB_PORT_COUNT  2
`define LB_DATA_WIDTH  32
`define LB_KEEP_WIDTH  4
`define LB_PORT_WIDTH  2

// core/slot tag layout, five bits below the core field.
`define LB_CORE_WIDTH  4
`define LB_SLOT_WIDTH  3
`define LB_TAG_WIDTH   (`LB_CORE_WIDTH + 5)

// buffering and status.
`define LB_FIFO_DEPTH  16
`define LB_COUNT_WIDTH 16

`endif

// File: loopback_stream_fifo.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module loopback_stream_fifo
    import loopback_stream_pkg::*;
#(
    parameter int DEPTH = `LB_FIFO_DEPTH
) (
    input  logic         clk,
    input  logic         rst_n,

    input  stream_data_t in_data,
    input  stream_keep_t in_keep,
    input  logic         in_last,
    input  port_num_t    in_port,
    input  msg_tag_t     in_tag,
    input  logic         in_valid,
    output logic         in_ready,

    output stream_data_t out_data,
    output stream_keep_t out_keep,
    output logic         out_last,
    output port_num_t    out_port,
    output msg_tag_t     out_tag,
    output logic         out_valid,
    input  logic         out_ready
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    stream_data_t data_mem [DEPTH];
    stream_keep_t keep_mem [DEPTH];
    logic         last_mem [DEPTH];
    port_num_t    port_mem [DEPTH];
    msg_tag_t     tag_mem  [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 push;
    logic                 pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // head moves into the output register when that register is free.
    assign pop      = (count != '0) && (!out_valid || out_ready);
    // a full buffer still takes a beat while the head leaves.
    assign in_ready = (count != CNT_WIDTH'(DEPTH)) || pop;
    assign push     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (pop) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            keep_mem[wr_ptr] <= in_keep;
            last_mem[wr_ptr] <= in_last;
            port_mem[wr_ptr] <= in_port;
            tag_mem[wr_ptr]  <= in_tag;
        end
    end

    // output register.
    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= data_mem[rd_ptr];
            out_keep <= keep_mem[rd_ptr];
            out_last <= last_mem[rd_ptr];
            out_port <= port_mem[rd_ptr];
            out_tag  <= tag_mem[rd_ptr];
        end
    end

endmodule

// File: loopback_stream_pkg.sv
`include "loopback_settings.svh"

package loopback_stream_pkg;

    // one beat of payload and its byte enables.
    typedef logic [`LB_DATA_WIDTH-1:0] stream_data_t;
    typedef logic [`LB_KEEP_WIDTH-1:0] stream_keep_t;

    // stream port number, carried on tdest in and tuser out.
    typedef logic [`LB_PORT_WIDTH-1:0] port_num_t;

    // core number in the top bits, slot number in the low bits.
    typedef logic [`LB_TAG_WIDTH-1:0] msg_tag_t;

    // table index, core field then slot field.
    typedef logic [`LB_CORE_WIDTH+`LB_SLOT_WIDTH-1:0] tag_index_t;

endpackage

// File: msg_bus_fsm.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module msg_bus_fsm
    import loopback_stream_pkg::*;
    import loopback_bus_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  wb_addr_t                            wb_adr,
    input  wb_data_t                            wb_dat_w,
    output wb_data_t                            wb_dat_r,
    output logic                                wb_ack,

    input  frame_count_t [`LB_PORT_COUNT-1:0]   frame_count,

    output logic                                tbl_wr_en,
    output tag_index_t                          tbl_wr_index,
    output msg_tag_t                            tbl_wr_tag
);

    bus_state_t state;
    logic       request;
    logic       is_count;

    assign request  = wb_cyc && wb_stb;
    assign is_count = wb_adr[7];

    // **********************************************************************
    // state machine. master holds address and data until ack.
    // **********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= bus_idle;
            wb_ack <= 1'b0;
        end else begin
            case (state)
                bus_idle: begin
                    if (request) begin
                        state <= wb_we ? bus_write : bus_read;
                    end
                end
                bus_write, bus_read: begin
                    state  <= bus_ack;
                    wb_ack <= 1'b1;
                end
                bus_ack: begin
                    // single ack pulse, then wait for stb to drop.
                    wb_ack <= 1'b0;
                    if (!request) begin
                        state <= bus_idle;
                    end
                end
                default: begin
                    state  <= bus_idle;
                    wb_ack <= 1'b0;
                end
            endcase
        end
    end

    // **********************************************************************
    // table write and counter read.
    // **********************************************************************

    // commits on the edge that raises ack.
    assign tbl_wr_en    = (state == bus_write) && !is_count;
    assign tbl_wr_index = wb_adr[$bits(tag_index_t)-1:0];
    assign tbl_wr_tag   = wb_dat_w[`LB_TAG_WIDTH-1:0];

    // table is write-only, reads back zero.
    always_ff @(posedge clk) begin
        if (state == bus_read) begin
            wb_dat_r <= is_count ? wb_data_t'(frame_count[wb_adr[0]]) : '0;
        end
    end

endmodule

// File: tb_loopback_msg.sv
`timescale 1ns/10ps
`include "loopback_settings.svh"

module tb_loopback_msg
    import loopback_stream_pkg::*;
    import loopback_bus_pkg::*;
();

    localparam int PORTS  = `LB_PORT_COUNT;
    localparam int DEPTH  = `LB_FIFO_DEPTH;
    localparam int FRAMES = 25;

    typedef struct packed {
        stream_data_t data;
        stream_keep_t keep;
        logic         last;
        msg_tag_t     tag;
        port_num_t    port;
    } beat_t;

    logic clk;
    logic rst_n;

    stream_data_t [PORTS-1:0] s_tdata;
    stream_keep_t [PORTS-1:0] s_tkeep;
    logic         [PORTS-1:0] s_tvalid;
    logic         [PORTS-1:0] s_tlast;
    msg_tag_t     [PORTS-1:0] s_tuser;
    port_num_t    [PORTS-1:0] s_tdest;
    logic         [PORTS-1:0] s_tready;
    stream_data_t [PORTS-1:0] m_tdata;
    stream_keep_t [PORTS-1:0] m_tkeep;
    logic         [PORTS-1:0] m_tvalid;
    logic         [PORTS-1:0] m_tlast;
    msg_tag_t     [PORTS-1:0] m_tdest;
    port_num_t    [PORTS-1:0] m_tuser;
    logic         [PORTS-1:0] m_tready;

    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    // reference model state.
    msg_tag_t     shadow [128];
    beat_t        exp_q [PORTS][$];
    frame_count_t model_frames [PORTS];

    logic [31:0] rng_state = 32'd7842;
    int          gen_beats = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        bp_mode = 1'b0;

    loopback_msg_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    task automatic compare_field(input string name, input int idx,
                                 input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error: %s[%0d] 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    // ******************************************************************
    // wishbone master.
    // ******************************************************************

    task automatic wb_transfer(input logic we, input wb_addr_t adr,
                               input wb_data_t dat, output wb_data_t rdata);
        int cycles;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        cycles   = 0;
        while (!wb_ack && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        // sampled on the first edge, ack on the next.
        assert (cycles == 2) else begin
            other_errors++;
            $display("wishbone ack came %0d cycles after the request, not 2", cycles);
        end
        rdata = wb_dat_r;
        if (we && wb_ack && !adr[7]) begin
            shadow[tag_index_t'(adr)] = msg_tag_t'(dat);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        assert (!wb_ack) else begin
            other_errors++;
            $display("wishbone ack stayed high for more than one cycle");
        end
    endtask

    // ******************************************************************
    // stream drivers.
    // ******************************************************************

    task automatic send_frames(input int p, input int n);
        int       len;
        int       gap;
        logic     hs;
        msg_tag_t tag;
        for (int f = 0; f < n; f++) begin
            len = 1 + int'(next_random() % 16'd6);
            tag = msg_tag_t'(next_random());
            s_tuser[p] = tag;
            s_tdest[p] = port_num_t'(next_random());
            for (int b = 0; b < len; b++) begin
                s_tdata[p]  = {next_random(), next_random()};
                s_tkeep[p]  = stream_keep_t'(next_random());
                s_tlast[p]  = (b == len - 1);
                s_tvalid[p] = 1'b1;
                gen_beats++;
                hs = 1'b0;
                while (!hs) begin
                    @(negedge clk);
                    hs = s_tready[p];
                    @(posedge clk);
                    #1;
                end
            end
            s_tvalid[p] = 1'b0;
            gap = int'(next_random() % 16'd3);
            repeat (gap) @(posedge clk);
            #1;
        end
    endtask

    // output back-pressure, long bursts of one level.
    initial begin : ready_driver
        int   burst_left [PORTS];
        logic burst_val [PORTS];
        m_tready = '1;
        for (int p = 0; p < PORTS; p++) begin
            burst_left[p] = 0;
        end
        forever begin
            @(posedge clk);
            #1;
            for (int p = 0; p < PORTS; p++) begin
                if (!bp_mode) begin
                    m_tready[p] = 1'b1;
                end else begin
                    if (burst_left[p] == 0) begin
                        burst_left[p] = 1 + int'(next_random() % 16'd24);
                        burst_val[p]  = (next_random() % 16'd10) < 3;
                    end
                    burst_left[p]--;
                    m_tready[p] = burst_val[p];
                end
            end
        end
    end

    // ******************************************************************
    // model and output checks, sampled mid-cycle.
    // ******************************************************************

    always @(negedge clk) begin : monitor
        beat_t      exp_beat;
        tag_index_t idx;
        if (rst_n) begin
            for (int p = 0; p < PORTS; p++) begin
                if (!s_tready[p]) begin
                    assert (exp_q[p].size() > DEPTH - 1) else begin
                        other_errors++;
                        $display("s_tready[%0d] low with only %0d beats held",
                                 p, exp_q[p].size());
                    end
                end
                if (m_tvalid[p] && m_tready[p]) begin
                    assert (exp_q[p].size() != 0) else begin
                        other_errors++;
                        $display("port %0d delivered a beat that was never sent", p);
                    end
                    if (exp_q[p].size() != 0) begin
                        exp_beat = exp_q[p].pop_front();
                        compare_field("m_tdata", p, m_tdata[p], exp_beat.data);
                        compare_field("m_tkeep", p, m_tkeep[p], exp_beat.keep);
                        compare_field("m_tlast", p, m_tlast[p], exp_beat.last);
                        compare_field("m_tdest", p, m_tdest[p], exp_beat.tag);
                        compare_field("m_tuser", p, m_tuser[p], exp_beat.port);
                        if (exp_beat.last) begin
                            model_frames[p]++;
                        end
                    end
                end
                if (s_tvalid[p] && s_tready[p]) begin
                    // core field from the top of the tag, slot from the bottom.
                    idx = {s_tuser[p][8:5], s_tuser[p][2:0]};
                    exp_q[p].push_back({s_tdata[p], s_tkeep[p], s_tlast[p],
                                        shadow[idx], s_tdest[p]});
                end
            end
        end
    end

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int p = 0; p < PORTS; p++) begin
            total += exp_q[p].size();
        end
        return total;
    endfunction

    task automatic wait_drain();
        while (pending_beats() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic run_traffic();
        fork
            send_frames(0, FRAMES);
            send_frames(1, FRAMES);
        join
        wait_drain();
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * gen_beats + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d beats still expected",
                 cycles, pending_beats());
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        wb_data_t rd;
        rst_n    = 1'b0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tvalid = '0;
        s_tlast  = '0;
        s_tuser  = '0;
        s_tdest  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int p = 0; p < PORTS; p++) begin
            model_frames[p] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // state after reset.
        compare_field("wb_ack", 0, wb_ack, 1'b0);
        for (int p = 0; p < PORTS; p++) begin
            compare_field("m_tvalid", p, m_tvalid[p], 1'b0);
            compare_field("s_tready", p, s_tready[p], 1'b1);
            wb_transfer(1'b0, 8'h80 | wb_addr_t'(p), '0, rd);
            compare_field("wb_dat_r", p, rd, '0);
        end

        // fill the whole table.
        for (int i = 0; i < 128; i++) begin
            wb_transfer(1'b1, wb_addr_t'(i), next_random(), rd);
        end

        run_traffic();

        bp_mode = 1'b1;
        run_traffic();
        bp_mode = 1'b0;

        // rewrite half the table while the streams are idle.
        for (int i = 0; i < 128; i += 2) begin
            wb_transfer(1'b1, wb_addr_t'(i), next_random(), rd);
        end
        run_traffic();

        for (int p = 0; p < PORTS; p++) begin
            wb_transfer(1'b0, 8'h80 | wb_addr_t'(p), '0, rd);
            compare_field("wb_dat_r", p, rd, model_frames[p]);
        end

        // table reads give zero, even with the counters nonzero.
        wb_transfer(1'b0, 8'h2b, '0, rd);
        compare_field("wb_dat_r", 0, rd, '0);

        $display("summary: %0d value errors, %0d other errors, %0d beats sent",
                 value_errors, other_errors, gen_beats);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
